// File: Bender.yml
package:
  name: instr_dec

sources:
  - common/instr_pkg.sv
  - source/strobe_decode.sv
  - source/alu_op_map.sv
  - source/instr_dec.sv
  - target: simulation
    files:
      - verif/instr_dec_properties.sv
      - verif/instr_dec_tb.sv

// File: common/instr_pkg.sv
package instr_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int opcode_w = 7; // Opcode bits
  localparam int alu_op_w = 6; // ALU operation bits

  // --------------------------------------------------
  // Opcodes
  // --------------------------------------------------
  // Memory, stack and I/O
  localparam logic [opcode_w-1:0] op_lod    = 7'd0;  // Load acc from memory
  localparam logic [opcode_w-1:0] op_p_lod  = 7'd1;  // Push then load
  localparam logic [opcode_w-1:0] op_ldi    = 7'd2;  // Indirect load
  localparam logic [opcode_w-1:0] op_ili    = 7'd3;  // Indirect load, inverted address
  localparam logic [opcode_w-1:0] op_set    = 7'd4;  // Store acc to memory
  localparam logic [opcode_w-1:0] op_set_p  = 7'd5;  // Store then pop
  localparam logic [opcode_w-1:0] op_sti    = 7'd6;  // Indirect store
  localparam logic [opcode_w-1:0] op_isi    = 7'd7;  // Indirect store, inverted address
  localparam logic [opcode_w-1:0] op_psh    = 7'd8;
  localparam logic [opcode_w-1:0] op_pop    = 7'd9;
  localparam logic [opcode_w-1:0] op_inn    = 7'd10; // Input port read
  localparam logic [opcode_w-1:0] op_p_inn  = 7'd11; // Push then input
  localparam logic [opcode_w-1:0] op_out    = 7'd12; // Output port write

  // Jumps and calls, handled by the fetch logic
  localparam logic [opcode_w-1:0] op_jmp    = 7'd13;
  localparam logic [opcode_w-1:0] op_jiz    = 7'd14; // Jump if zero
  localparam logic [opcode_w-1:0] op_cal    = 7'd15;
  localparam logic [opcode_w-1:0] op_ret    = 7'd16;

  // Two-operand groups, memory form then stack form
  localparam logic [opcode_w-1:0] op_add    = 7'd17;
  localparam logic [opcode_w-1:0] op_s_add  = 7'd18;
  localparam logic [opcode_w-1:0] op_mlt    = 7'd21;
  localparam logic [opcode_w-1:0] op_s_mlt  = 7'd22;
  localparam logic [opcode_w-1:0] op_div    = 7'd25;
  localparam logic [opcode_w-1:0] op_s_div  = 7'd26;
  localparam logic [opcode_w-1:0] op_mod    = 7'd29;
  localparam logic [opcode_w-1:0] op_s_mod  = 7'd30;
  localparam logic [opcode_w-1:0] op_sgn    = 7'd31; // Copy sign
  localparam logic [opcode_w-1:0] op_s_sgn  = 7'd32;
  localparam logic [opcode_w-1:0] op_and    = 7'd62;
  localparam logic [opcode_w-1:0] op_s_and  = 7'd63;
  localparam logic [opcode_w-1:0] op_orr    = 7'd64;
  localparam logic [opcode_w-1:0] op_s_orr  = 7'd65;
  localparam logic [opcode_w-1:0] op_xor    = 7'd66;
  localparam logic [opcode_w-1:0] op_s_xor  = 7'd67;
  localparam logic [opcode_w-1:0] op_lan    = 7'd71; // Logical and
  localparam logic [opcode_w-1:0] op_s_lan  = 7'd72;
  localparam logic [opcode_w-1:0] op_lor    = 7'd73; // Logical or
  localparam logic [opcode_w-1:0] op_s_lor  = 7'd74;
  localparam logic [opcode_w-1:0] op_les    = 7'd78; // Less than
  localparam logic [opcode_w-1:0] op_s_les  = 7'd79;
  localparam logic [opcode_w-1:0] op_gre    = 7'd82; // Greater than
  localparam logic [opcode_w-1:0] op_s_gre  = 7'd83;
  localparam logic [opcode_w-1:0] op_equ    = 7'd86;
  localparam logic [opcode_w-1:0] op_s_equ  = 7'd87;
  localparam logic [opcode_w-1:0] op_shl    = 7'd88;
  localparam logic [opcode_w-1:0] op_s_shl  = 7'd89;
  localparam logic [opcode_w-1:0] op_shr    = 7'd90;
  localparam logic [opcode_w-1:0] op_s_shr  = 7'd91;
  localparam logic [opcode_w-1:0] op_srs    = 7'd92; // Arithmetic shift right
  localparam logic [opcode_w-1:0] op_s_srs  = 7'd93;

  // One-operand groups: acc, memory, push-memory
  localparam logic [opcode_w-1:0] op_neg    = 7'd35;
  localparam logic [opcode_w-1:0] op_neg_m  = 7'd36;
  localparam logic [opcode_w-1:0] op_p_neg_m = 7'd37;
  localparam logic [opcode_w-1:0] op_abs    = 7'd41;
  localparam logic [opcode_w-1:0] op_abs_m  = 7'd42;
  localparam logic [opcode_w-1:0] op_p_abs_m = 7'd43;
  localparam logic [opcode_w-1:0] op_pst    = 7'd47; // Clamp negative to zero
  localparam logic [opcode_w-1:0] op_pst_m  = 7'd48;
  localparam logic [opcode_w-1:0] op_p_pst_m = 7'd49;
  localparam logic [opcode_w-1:0] op_nrm    = 7'd53; // Divide by constant
  localparam logic [opcode_w-1:0] op_nrm_m  = 7'd54;
  localparam logic [opcode_w-1:0] op_p_nrm_m = 7'd55;
  localparam logic [opcode_w-1:0] op_inv    = 7'd68; // Bitwise invert
  localparam logic [opcode_w-1:0] op_inv_m  = 7'd69;
  localparam logic [opcode_w-1:0] op_p_inv_m = 7'd70;
  localparam logic [opcode_w-1:0] op_lin    = 7'd75; // Logical invert
  localparam logic [opcode_w-1:0] op_lin_m  = 7'd76;
  localparam logic [opcode_w-1:0] op_p_lin_m = 7'd77;

  localparam logic [opcode_w-1:0] op_nop    = 7'd94;

  // --------------------------------------------------
  // ALU operation codes
  // --------------------------------------------------
  localparam logic [alu_op_w-1:0] alu_none  = 6'd0;
  localparam logic [alu_op_w-1:0] alu_load  = 6'd1;  // Pass operand to acc
  localparam logic [alu_op_w-1:0] alu_add   = 6'd2;
  localparam logic [alu_op_w-1:0] alu_mlt   = 6'd4;
  localparam logic [alu_op_w-1:0] alu_div   = 6'd6;
  localparam logic [alu_op_w-1:0] alu_mod   = 6'd8;
  localparam logic [alu_op_w-1:0] alu_sgn   = 6'd9;
  localparam logic [alu_op_w-1:0] alu_neg   = 6'd11;
  localparam logic [alu_op_w-1:0] alu_neg_m = 6'd12;
  localparam logic [alu_op_w-1:0] alu_abs   = 6'd15;
  localparam logic [alu_op_w-1:0] alu_abs_m = 6'd16;
  localparam logic [alu_op_w-1:0] alu_pst   = 6'd19;
  localparam logic [alu_op_w-1:0] alu_pst_m = 6'd20;
  localparam logic [alu_op_w-1:0] alu_nrm   = 6'd23;
  localparam logic [alu_op_w-1:0] alu_nrm_m = 6'd24;
  localparam logic [alu_op_w-1:0] alu_and   = 6'd29;
  localparam logic [alu_op_w-1:0] alu_orr   = 6'd30;
  localparam logic [alu_op_w-1:0] alu_xor   = 6'd31;
  localparam logic [alu_op_w-1:0] alu_inv   = 6'd32;
  localparam logic [alu_op_w-1:0] alu_inv_m = 6'd33;
  localparam logic [alu_op_w-1:0] alu_lan   = 6'd34;
  localparam logic [alu_op_w-1:0] alu_lor   = 6'd35;
  localparam logic [alu_op_w-1:0] alu_lin   = 6'd36;
  localparam logic [alu_op_w-1:0] alu_lin_m = 6'd37;
  localparam logic [alu_op_w-1:0] alu_les   = 6'd38;
  localparam logic [alu_op_w-1:0] alu_gre   = 6'd40;
  localparam logic [alu_op_w-1:0] alu_equ   = 6'd42;
  localparam logic [alu_op_w-1:0] alu_shl   = 6'd43;
  localparam logic [alu_op_w-1:0] alu_shr   = 6'd44;
  localparam logic [alu_op_w-1:0] alu_srs   = 6'd45;

endpackage

// File: filelist.f
common/instr_pkg.sv
source/strobe_decode.sv
source/alu_op_map.sv
source/instr_dec.sv
verif/instr_dec_properties.sv
verif/instr_dec_tb.sv

// File: source/alu_op_map.sv
module alu_op_map (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [instr_pkg::opcode_w-1:0] opcode,
  output logic [instr_pkg::alu_op_w-1:0] alu_op
);

  logic [instr_pkg::alu_op_w-1:0] alu_next; // Code for the current opcode
  logic                           hold;     // Keep the previous code

  // --------------------------------------------------
  // Opcode to ALU operation table
  // --------------------------------------------------
  always_comb begin
    alu_next = instr_pkg::alu_none;
    hold     = 1'b0;
    case (opcode)
      // Memory and stack moves
      instr_pkg::op_lod,
      instr_pkg::op_p_lod,
      instr_pkg::op_ldi,
      instr_pkg::op_ili,
      instr_pkg::op_set_p,
      instr_pkg::op_pop:    alu_next = instr_pkg::alu_load;  // Acc takes the operand
      instr_pkg::op_set,
      instr_pkg::op_sti,
      instr_pkg::op_isi,
      instr_pkg::op_psh:    alu_next = instr_pkg::alu_none;  // Acc unchanged
      // I/O ports
      instr_pkg::op_inn,
      instr_pkg::op_p_inn,
      instr_pkg::op_out:    alu_next = instr_pkg::alu_none;
      // Flow control lives in the fetch stage
      instr_pkg::op_jmp,
      instr_pkg::op_jiz,
      instr_pkg::op_cal,
      instr_pkg::op_ret:    alu_next = instr_pkg::alu_none;

      // Arithmetic, memory and stack forms share a code
      instr_pkg::op_add, instr_pkg::op_s_add: alu_next = instr_pkg::alu_add;
      instr_pkg::op_mlt, instr_pkg::op_s_mlt: alu_next = instr_pkg::alu_mlt;
      instr_pkg::op_div, instr_pkg::op_s_div: alu_next = instr_pkg::alu_div;
      instr_pkg::op_mod, instr_pkg::op_s_mod: alu_next = instr_pkg::alu_mod;
      instr_pkg::op_sgn, instr_pkg::op_s_sgn: alu_next = instr_pkg::alu_sgn;
      // Bitwise logic
      instr_pkg::op_and, instr_pkg::op_s_and: alu_next = instr_pkg::alu_and;
      instr_pkg::op_orr, instr_pkg::op_s_orr: alu_next = instr_pkg::alu_orr;
      instr_pkg::op_xor, instr_pkg::op_s_xor: alu_next = instr_pkg::alu_xor;
      // Logical and compare
      instr_pkg::op_lan, instr_pkg::op_s_lan: alu_next = instr_pkg::alu_lan;
      instr_pkg::op_lor, instr_pkg::op_s_lor: alu_next = instr_pkg::alu_lor;
      instr_pkg::op_les, instr_pkg::op_s_les: alu_next = instr_pkg::alu_les;
      instr_pkg::op_gre, instr_pkg::op_s_gre: alu_next = instr_pkg::alu_gre;
      instr_pkg::op_equ, instr_pkg::op_s_equ: alu_next = instr_pkg::alu_equ;
      // Shifts
      instr_pkg::op_shl, instr_pkg::op_s_shl: alu_next = instr_pkg::alu_shl;
      instr_pkg::op_shr, instr_pkg::op_s_shr: alu_next = instr_pkg::alu_shr;
      instr_pkg::op_srs, instr_pkg::op_s_srs: alu_next = instr_pkg::alu_srs;

      // One-operand, push-memory reuses the memory code
      instr_pkg::op_neg:                          alu_next = instr_pkg::alu_neg;
      instr_pkg::op_neg_m, instr_pkg::op_p_neg_m: alu_next = instr_pkg::alu_neg_m;
      instr_pkg::op_abs:                          alu_next = instr_pkg::alu_abs;
      instr_pkg::op_abs_m, instr_pkg::op_p_abs_m: alu_next = instr_pkg::alu_abs_m;
      instr_pkg::op_pst:                          alu_next = instr_pkg::alu_pst;
      instr_pkg::op_pst_m, instr_pkg::op_p_pst_m: alu_next = instr_pkg::alu_pst_m;
      instr_pkg::op_nrm:                          alu_next = instr_pkg::alu_nrm;
      instr_pkg::op_nrm_m, instr_pkg::op_p_nrm_m: alu_next = instr_pkg::alu_nrm_m;
      instr_pkg::op_inv:                          alu_next = instr_pkg::alu_inv;
      instr_pkg::op_inv_m, instr_pkg::op_p_inv_m: alu_next = instr_pkg::alu_inv_m;
      instr_pkg::op_lin:                          alu_next = instr_pkg::alu_lin;
      instr_pkg::op_lin_m, instr_pkg::op_p_lin_m: alu_next = instr_pkg::alu_lin_m;

      instr_pkg::op_nop: hold = 1'b1;  // Bubble, ALU keeps going
      default:           hold = 1'b1;  // Float forms and unused codes
    endcase
  end

  // --------------------------------------------------
  // ALU operation register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      alu_op <= instr_pkg::alu_none;
    end else if (!hold) begin
      alu_op <= alu_next;            // One cycle behind the opcode
    end
  end

endmodule

// File: source/instr_dec.sv
module instr_dec #(
  parameter bit stack_en    = 1'b1, // Stack strobes present
  parameter bit io_en       = 1'b1, // I/O strobes present
  parameter bit indirect_en = 1'b1  // Indirect load/store present
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [instr_pkg::opcode_w-1:0] opcode,
  output logic                           push,
  output logic                           pop,
  output logic                           mem_wr,
  output logic                           req_in,
  output logic                           out_en,
  output logic                           ldi,
  output logic                           sti,
  output logic                           fft,
  output logic [instr_pkg::alu_op_w-1:0] alu_op
);

  // Same-cycle control strobes
  strobe_decode #(
    .stack_en    (stack_en),
    .io_en       (io_en),
    .indirect_en (indirect_en)
  ) strobe_decode_i (
    .opcode (opcode),
    .push   (push),
    .pop    (pop),
    .mem_wr (mem_wr),
    .req_in (req_in),
    .out_en (out_en),
    .ldi    (ldi),
    .sti    (sti),
    .fft    (fft)
  );

  // Registered ALU operation
  alu_op_map alu_op_map_i (
    .clk    (clk),
    .rst    (rst),
    .opcode (opcode),
    .alu_op (alu_op)
  );

endmodule

// File: source/strobe_decode.sv
module strobe_decode #(
  parameter bit stack_en    = 1'b1, // Data-stack push and pop
  parameter bit io_en       = 1'b1, // Input and output ports
  parameter bit indirect_en = 1'b1  // Indirect addressing
) (
  input  logic [instr_pkg::opcode_w-1:0] opcode,
  output logic                           push,
  output logic                           pop,
  output logic                           mem_wr,
  output logic                           req_in,
  output logic                           out_en,
  output logic                           ldi,
  output logic                           sti,
  output logic                           fft
);

  // --------------------------------------------------
  // Opcode matches
  // --------------------------------------------------
  logic is_p_lod;
  logic is_ldi;
  logic is_ili;
  logic is_set;
  logic is_set_p;
  logic is_sti;
  logic is_isi;
  logic is_psh;
  logic is_pop;
  logic is_inn;
  logic is_p_inn;
  logic is_out;
  logic is_p_mem; // Push-memory one-operand forms
  logic is_s_two; // Stack two-operand forms

  assign is_p_lod = opcode == instr_pkg::op_p_lod;
  assign is_ldi   = opcode == instr_pkg::op_ldi;
  assign is_ili   = opcode == instr_pkg::op_ili;
  assign is_set   = opcode == instr_pkg::op_set;
  assign is_set_p = opcode == instr_pkg::op_set_p;
  assign is_sti   = opcode == instr_pkg::op_sti;
  assign is_isi   = opcode == instr_pkg::op_isi;
  assign is_psh   = opcode == instr_pkg::op_psh;
  assign is_pop   = opcode == instr_pkg::op_pop;
  assign is_inn   = opcode == instr_pkg::op_inn;
  assign is_p_inn = opcode == instr_pkg::op_p_inn;
  assign is_out   = opcode == instr_pkg::op_out;

  assign is_p_mem = opcode inside {instr_pkg::op_p_neg_m, instr_pkg::op_p_abs_m,
                                   instr_pkg::op_p_pst_m, instr_pkg::op_p_nrm_m,
                                   instr_pkg::op_p_inv_m, instr_pkg::op_p_lin_m};

  assign is_s_two = opcode inside {instr_pkg::op_s_add, instr_pkg::op_s_mlt,
                                   instr_pkg::op_s_div, instr_pkg::op_s_mod,
                                   instr_pkg::op_s_sgn, instr_pkg::op_s_and,
                                   instr_pkg::op_s_orr, instr_pkg::op_s_xor,
                                   instr_pkg::op_s_lan, instr_pkg::op_s_lor,
                                   instr_pkg::op_s_les, instr_pkg::op_s_gre,
                                   instr_pkg::op_s_equ, instr_pkg::op_s_shl,
                                   instr_pkg::op_s_shr, instr_pkg::op_s_srs};

  // --------------------------------------------------
  // Strobes
  // --------------------------------------------------
  // P_INN pushes the port value, so it also needs the I/O group
  assign push = stack_en & (is_p_lod | is_psh | (io_en & is_p_inn) | is_p_mem);

  // STI and ISI consume the address from the stack
  assign pop  = stack_en & (is_set_p | is_pop | is_s_two |
                            (indirect_en & (is_sti | is_isi)));

  assign mem_wr = is_set | is_set_p | (indirect_en & (is_sti | is_isi));

  assign ldi = indirect_en & (is_ldi | is_ili); // Indirect read address
  assign sti = indirect_en & (is_sti | is_isi); // Indirect write address
  assign fft = indirect_en & (is_ili | is_isi); // Bit-reversed address

  assign req_in = io_en & (is_inn | is_p_inn);  // Input request
  assign out_en = io_en & is_out;

endmodule

// File: verif/instr_dec_properties.sv
module instr_dec_properties #(
  parameter bit stack_en    = 1'b1,
  parameter bit io_en       = 1'b1,
  parameter bit indirect_en = 1'b1
) (
  input logic                           clk,
  input logic                           rst,
  input logic [instr_pkg::opcode_w-1:0] opcode,
  input logic                           push,
  input logic                           pop,
  input logic                           mem_wr,
  input logic                           req_in,
  input logic                           out_en,
  input logic                           ldi,
  input logic                           sti,
  input logic                           fft,
  input logic [instr_pkg::alu_op_w-1:0] alu_op
);

  int unsigned strobe_errs = 0; // Strobe vector mismatches
  int unsigned alu_errs    = 0; // alu_op mismatches
  int unsigned rule_errs   = 0; // push/pop and fft rules

  // --------------------------------------------------
  // Reference decode
  // --------------------------------------------------
  // Bit order {push, pop, mem_wr, req_in, out_en, ldi, sti, fft}
  function automatic logic [7:0] strobe_ref(input logic [instr_pkg::opcode_w-1:0] op);
    logic [7:0] v;
    logic [7:0] mask;
    mask = {stack_en, stack_en, 1'b1, io_en, io_en, {3{indirect_en}}}; // Group enables
    case (op) inside
      instr_pkg::op_p_lod, instr_pkg::op_psh: v = 8'b1000_0000;
      instr_pkg::op_p_inn: v = {io_en, 7'b001_0000};             // Push needs the port too
      instr_pkg::op_inn:   v = 8'b0001_0000;
      instr_pkg::op_out:   v = 8'b0000_1000;
      instr_pkg::op_set:   v = 8'b0010_0000;
      instr_pkg::op_set_p: v = 8'b0110_0000;
      instr_pkg::op_pop:   v = 8'b0100_0000;
      instr_pkg::op_ldi:   v = 8'b0000_0100;
      instr_pkg::op_ili:   v = 8'b0000_0101;                      // Inverted address
      instr_pkg::op_sti:   v = {1'b0, {2{indirect_en}}, 5'b00010}; // Pop and write gated
      instr_pkg::op_isi:   v = {1'b0, {2{indirect_en}}, 5'b00011};
      instr_pkg::op_p_neg_m, instr_pkg::op_p_abs_m, instr_pkg::op_p_pst_m,
      instr_pkg::op_p_nrm_m, instr_pkg::op_p_inv_m, instr_pkg::op_p_lin_m: v = 8'b1000_0000;
      instr_pkg::op_s_add, instr_pkg::op_s_mlt, instr_pkg::op_s_div, instr_pkg::op_s_mod,
      instr_pkg::op_s_sgn, instr_pkg::op_s_and, instr_pkg::op_s_orr, instr_pkg::op_s_xor,
      instr_pkg::op_s_lan, instr_pkg::op_s_lor, instr_pkg::op_s_les, instr_pkg::op_s_gre,
      instr_pkg::op_s_equ, instr_pkg::op_s_shl, instr_pkg::op_s_shr,
      instr_pkg::op_s_srs: v = 8'b0100_0000;                     // Stack forms pop
      default:             v = 8'b0;
    endcase
    return v & mask;
  endfunction

  // Returns {update, code}, update low where alu_op holds
  function automatic logic [instr_pkg::alu_op_w:0] alu_ref(
    input logic [instr_pkg::opcode_w-1:0] op
  );
    logic [instr_pkg::alu_op_w-1:0] code;
    logic                           upd;
    upd  = 1'b1;
    code = instr_pkg::alu_none;
    case (op) inside
      instr_pkg::op_lod, instr_pkg::op_p_lod, instr_pkg::op_ldi, instr_pkg::op_ili,
      instr_pkg::op_set_p, instr_pkg::op_pop:       code = instr_pkg::alu_load;
      [instr_pkg::op_lod:instr_pkg::op_ret]:        code = instr_pkg::alu_none; // Moves, I/O, flow
      [instr_pkg::op_add:instr_pkg::op_s_add]:      code = instr_pkg::alu_add;
      [instr_pkg::op_mlt:instr_pkg::op_s_mlt]:      code = instr_pkg::alu_mlt;
      [instr_pkg::op_div:instr_pkg::op_s_div]:      code = instr_pkg::alu_div;
      [instr_pkg::op_mod:instr_pkg::op_s_mod]:      code = instr_pkg::alu_mod;
      [instr_pkg::op_sgn:instr_pkg::op_s_sgn]:      code = instr_pkg::alu_sgn;
      [instr_pkg::op_and:instr_pkg::op_s_and]:      code = instr_pkg::alu_and;
      [instr_pkg::op_orr:instr_pkg::op_s_orr]:      code = instr_pkg::alu_orr;
      [instr_pkg::op_xor:instr_pkg::op_s_xor]:      code = instr_pkg::alu_xor;
      [instr_pkg::op_lan:instr_pkg::op_s_lan]:      code = instr_pkg::alu_lan;
      [instr_pkg::op_lor:instr_pkg::op_s_lor]:      code = instr_pkg::alu_lor;
      [instr_pkg::op_les:instr_pkg::op_s_les]:      code = instr_pkg::alu_les;
      [instr_pkg::op_gre:instr_pkg::op_s_gre]:      code = instr_pkg::alu_gre;
      [instr_pkg::op_equ:instr_pkg::op_s_equ]:      code = instr_pkg::alu_equ;
      [instr_pkg::op_shl:instr_pkg::op_s_shl]:      code = instr_pkg::alu_shl;
      [instr_pkg::op_shr:instr_pkg::op_s_shr]:      code = instr_pkg::alu_shr;
      [instr_pkg::op_srs:instr_pkg::op_s_srs]:      code = instr_pkg::alu_srs;
      instr_pkg::op_neg:                            code = instr_pkg::alu_neg;
      [instr_pkg::op_neg_m:instr_pkg::op_p_neg_m]:  code = instr_pkg::alu_neg_m;
      instr_pkg::op_abs:                            code = instr_pkg::alu_abs;
      [instr_pkg::op_abs_m:instr_pkg::op_p_abs_m]:  code = instr_pkg::alu_abs_m;
      instr_pkg::op_pst:                            code = instr_pkg::alu_pst;
      [instr_pkg::op_pst_m:instr_pkg::op_p_pst_m]:  code = instr_pkg::alu_pst_m;
      instr_pkg::op_nrm:                            code = instr_pkg::alu_nrm;
      [instr_pkg::op_nrm_m:instr_pkg::op_p_nrm_m]:  code = instr_pkg::alu_nrm_m;
      instr_pkg::op_inv:                            code = instr_pkg::alu_inv;
      [instr_pkg::op_inv_m:instr_pkg::op_p_inv_m]:  code = instr_pkg::alu_inv_m;
      instr_pkg::op_lin:                            code = instr_pkg::alu_lin;
      [instr_pkg::op_lin_m:instr_pkg::op_p_lin_m]:  code = instr_pkg::alu_lin_m;
      default:                                      upd  = 1'b0; // NOP, float, above NOP
    endcase
    return {upd, code};
  endfunction

  // --------------------------------------------------
  // Previous cycle and expected alu_op
  // --------------------------------------------------
  logic                           prev_valid = 1'b0; // Low until the first edge
  logic                           prev_rst;
  logic [instr_pkg::opcode_w-1:0] prev_op;
  logic [instr_pkg::alu_op_w-1:0] prev_alu;
  logic [instr_pkg::alu_op_w:0]   prev_ref;
  logic [instr_pkg::alu_op_w-1:0] alu_exp;

  always @(posedge clk) begin
    prev_valid <= 1'b1;
    prev_rst   <= rst;
    prev_op    <= opcode;
    prev_alu   <= alu_op;
  end

  assign prev_ref = alu_ref(prev_op);
  assign alu_exp  = prev_rst ? instr_pkg::alu_none :
                    prev_ref[instr_pkg::alu_op_w] ? prev_ref[instr_pkg::alu_op_w-1:0] :
                    prev_alu;                                    // Hold case

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  a_strobes: assert property (@(posedge clk)
      {push, pop, mem_wr, req_in, out_en, ldi, sti, fft} == strobe_ref(opcode))
    else begin
      $error("Mismatch push,pop,mem_wr,req_in,out_en,ldi,sti,fft: expected %h got %h (opcode %h)",
             strobe_ref($sampled(opcode)),
             $sampled({push, pop, mem_wr, req_in, out_en, ldi, sti, fft}), $sampled(opcode));
      strobe_errs++;
    end

  a_alu_op: assert property (@(posedge clk) prev_valid |-> alu_op == alu_exp)
    else begin
      $error("Mismatch alu_op: expected %h got %h (previous opcode %h)",
             $sampled(alu_exp), $sampled(alu_op), $sampled(prev_op));
      alu_errs++;
    end

  a_push_pop: assert property (@(posedge clk) !(push && pop))
    else begin
      $error("push and pop are high in the same cycle for opcode %h", $sampled(opcode));
      rule_errs++;
    end

  a_fft: assert property (@(posedge clk) fft |-> (ldi || sti))
    else begin
      $error("fft is high without ldi or sti for opcode %h", $sampled(opcode));
      rule_errs++;
    end

endmodule

bind instr_dec instr_dec_properties #(
  .stack_en    (stack_en),
  .io_en       (io_en),
  .indirect_en (indirect_en)
) props_i (.*);

// File: verif/instr_dec_tb.sv
module instr_dec_tb;

  localparam int reset_cycles = 4;
  localparam int sweep_cycles = 128;  // Every 7-bit opcode
  localparam int rand_cycles  = 300;
  localparam int spare_cycles = 50;   // NOP runs, reset pulse, drain
  localparam int clk_period   = 8;

  logic                           clk = 1'b0;
  logic                           rst;
  logic [instr_pkg::opcode_w-1:0] opcode;
  logic                           push;
  logic                           pop;
  logic                           mem_wr;
  logic                           req_in;
  logic                           out_en;
  logic                           ldi;
  logic                           sti;
  logic                           fft;
  logic [instr_pkg::alu_op_w-1:0] alu_op;
  logic [15:0]                    lfsr = 16'd67; // Seed

  // Kept opcodes for the NOP run phase
  logic [instr_pkg::opcode_w-1:0] kept_ops [8] = '{
    instr_pkg::op_add, instr_pkg::op_neg_m, instr_pkg::op_s_xor, instr_pkg::op_lod,
    instr_pkg::op_p_abs_m, instr_pkg::op_jmp, instr_pkg::op_s_srs, instr_pkg::op_lin};

  always #(clk_period / 2) clk = ~clk;

  instr_dec #(
    .stack_en    (1'b1),
    .io_en       (1'b1),
    .indirect_en (1'b1)
  ) dut_i (.*);

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_opcode(output logic [instr_pkg::opcode_w-1:0] op);
    for (int b = 0; b < instr_pkg::opcode_w; b++) begin
      lfsr  = lfsr_next(lfsr);                 // One step per bit
      op[b] = lfsr[0];
    end
  endtask

  task automatic apply_opcode(input logic [instr_pkg::opcode_w-1:0] op);
    @(posedge clk);
    #1 opcode = op;                           // Just after the edge
  endtask

  task automatic print_counts();
    $display("Error counts: strobes %0d, alu_op %0d, strobe rules %0d",
             dut_i.props_i.strobe_errs, dut_i.props_i.alu_errs, dut_i.props_i.rule_errs);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [instr_pkg::opcode_w-1:0] op;
    int unsigned                    total;
    rst    = 1'b1;
    opcode = instr_pkg::op_nop;                // Quiet during reset
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;

    for (int i = 0; i < sweep_cycles; i++) begin
      apply_opcode(i[instr_pkg::opcode_w-1:0]);
    end

    repeat (rand_cycles) begin
      random_opcode(op);
      apply_opcode(op);
    end

    foreach (kept_ops[k]) begin
      apply_opcode(kept_ops[k]);
      repeat (k % 3 + 1) apply_opcode(instr_pkg::op_nop); // Runs of one to three
    end

    // Reset while a live ALU code is held
    apply_opcode(instr_pkg::op_mlt);
    @(posedge clk);
    #1 rst = 1'b1;
    @(posedge clk);
    #1 rst = 1'b0;
    apply_opcode(instr_pkg::op_nop);
    repeat (2) @(posedge clk);
    #1;                                        // Let the last action blocks run

    total = dut_i.props_i.strobe_errs + dut_i.props_i.alu_errs + dut_i.props_i.rule_errs;
    print_counts();
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((reset_cycles + sweep_cycles + rand_cycles + spare_cycles) * clk_period);
    $display("Timeout: the stimulus did not finish in time");
    print_counts();
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
